// ==== list.f ====
src/cacc_dlv_pkg.sv
src/cacc_dlv_regs.sv
src/cacc_delivery_ctrl.sv
src/cacc_dlv_buffer.sv
src/cacc_dlv_out.sv
src/cacc_dlv_top.sv
verification/tb_cacc_dlv.sv

// ==== run.sh ====
#!/bin/sh
# build and run the delivery stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_cacc_dlv -f list.f -o tb_cacc_dlv
./obj_dir/tb_cacc_dlv > sim.log 2>&1
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// ==== src/cacc_delivery_ctrl.sv ====
`timescale 1ns/1ps

module cacc_delivery_ctrl #(
  parameter int dbuf_depth        = 16,
  parameter int dbuf_aw           = 4,
  // at least 1, extra stages stand in for a write path with ECC
  parameter int ram_write_latency = 1
) (
  input  logic                                nvdla_core_clk,
  input  logic                                rst_n,
  input  logic                                op_en,
  input  logic                                dlv_valid,
  input  logic [cacc_dlv_pkg::dlv_data_w-1:0] dlv_data,
  input  logic                                dlv_stripe_end,
  input  logic                                dlv_layer_end,
  input  logic                                rd_ready,
  output logic                                dlv_accept,
  output logic                                done,
  output logic                                wr_en,
  output logic [dbuf_aw-1:0]                  wr_addr,
  output logic [cacc_dlv_pkg::dlv_data_w-1:0] wr_data,
  output logic                                rd_en,
  output logic [dbuf_aw-1:0]                  rd_addr,
  output logic                                rd_layer_end,
  output logic [dbuf_aw:0]                    dbuf_free
);

  cacc_dlv_pkg::ctrl_state_e      state;
  cacc_dlv_pkg::ctrl_state_e      state_nxt;
  logic                           layer_done;
  logic [dbuf_aw-1:0]             wr_ptr;
  logic [ram_write_latency-1:0]   push_dly;
  logic                           avl_add;
  logic [dbuf_aw:0]               avl_cnt;
  logic                           pop;
  logic [dbuf_aw-1:0]             rd_addr_q;
  logic [dbuf_aw-1:0]             tag0_addr;
  logic [dbuf_aw-1:0]             tag1_addr;
  logic                           tag0_vld;
  logic                           tag1_vld;

  // buffer addresses run 0 .. dbuf_depth-1 and then wrap
  function automatic logic [dbuf_aw-1:0] addr_inc(input logic [dbuf_aw-1:0] a);
    addr_inc = (a == dbuf_aw'(dbuf_depth - 1)) ? '0 : a + 1'b1;
  endfunction

  //////////////////////////////
  // operation FSM
  //////////////////////////////

  // the last beat of a layer carries both end flags
  assign dlv_accept = dlv_valid & (state == cacc_dlv_pkg::st_run);
  assign layer_done = dlv_accept & dlv_stripe_end & dlv_layer_end;

  always_comb begin
    state_nxt = state;
    case (state)
      // op_en is still high during the done cycle, so done blocks a restart
      cacc_dlv_pkg::st_idle: if (op_en && !done) state_nxt = cacc_dlv_pkg::st_run;
      cacc_dlv_pkg::st_run:  if (layer_done || !op_en) state_nxt = cacc_dlv_pkg::st_idle;
      default:               state_nxt = cacc_dlv_pkg::st_idle;
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cacc_dlv_pkg::st_idle;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      done  <= layer_done;
    end
  end

  //////////////////////////////
  // write side
  //////////////////////////////

  // wr_ptr is where the next accepted beat will land
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_en   <= 1'b0;
      wr_addr <= '0;
      wr_ptr  <= '0;
    end else begin
      wr_en <= dlv_accept;
      if (dlv_accept) begin
        wr_addr <= wr_ptr;
        wr_ptr  <= addr_inc(wr_ptr);
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (dlv_accept) begin
      wr_data <= dlv_data;
    end
  end

  // an entry becomes readable only after the write has settled in the RAM
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      push_dly <= '0;
    end else begin
      push_dly[0] <= dlv_accept;
      for (int i = 1; i < ram_write_latency; i++) begin
        push_dly[i] <= push_dly[i-1];
      end
    end
  end

  assign avl_add = push_dly[ram_write_latency-1];

  //////////////////////////////
  // read side
  //////////////////////////////

  // the read request is purely combinational from the available count
  assign rd_en   = (avl_cnt != '0);
  assign pop     = rd_en & rd_ready;
  assign rd_addr = rd_addr_q;

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      avl_cnt   <= '0;
      rd_addr_q <= '0;
      dbuf_free <= (dbuf_aw + 1)'(dbuf_depth);
    end else begin
      if (avl_add != pop) begin
        avl_cnt <= avl_add ? avl_cnt + 1'b1 : avl_cnt - 1'b1;
      end
      if (pop) begin
        rd_addr_q <= addr_inc(rd_addr_q);
      end
      // free space counts from acceptance, so the upstream sees it early
      if (dlv_accept != pop) begin
        dbuf_free <= dlv_accept ? dbuf_free - 1'b1 : dbuf_free + 1'b1;
      end
    end
  end

  //////////////////////////////
  // layer-end tags
  //////////////////////////////

  // a two-deep queue of last-beat addresses, tag0 is the head
  assign rd_layer_end = pop & tag0_vld & (rd_addr_q == tag0_addr);

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      tag0_vld  <= 1'b0;
      tag1_vld  <= 1'b0;
      tag0_addr <= '0;
      tag1_addr <= '0;
    end else begin
      case ({layer_done, rd_layer_end})
        2'b10: begin
          if (!tag0_vld) begin
            tag0_vld  <= 1'b1;
            tag0_addr <= wr_ptr;
          end else begin
            tag1_vld  <= 1'b1;
            tag1_addr <= wr_ptr;
          end
        end
        2'b01: begin
          tag0_vld  <= tag1_vld;
          tag0_addr <= tag1_addr;
          tag1_vld  <= 1'b0;
        end
        2'b11: begin
          // head retires while a new tag arrives, the queue shifts by one
          tag0_addr <= tag1_vld ? tag1_addr : wr_ptr;
          if (tag1_vld) begin
            tag1_addr <= wr_ptr;
          end
        end
        default: begin
          tag0_vld <= tag0_vld;
        end
      endcase
    end
  end

  a_avl_bound: assert property (
    @(posedge nvdla_core_clk) disable iff (!rst_n)
    avl_cnt <= (dbuf_aw + 1)'(dbuf_depth)
  );

  // the accumulator must throttle on dbuf_free
  a_no_accept_when_full: assert property (
    @(posedge nvdla_core_clk) disable iff (!rst_n)
    dlv_accept |-> dbuf_free != '0
  );

endmodule

// ==== src/cacc_dlv_buffer.sv ====
`timescale 1ns/1ps

module cacc_dlv_buffer #(
  parameter int dbuf_depth = 16,
  parameter int dbuf_aw    = 4
) (
  input  logic                                nvdla_core_clk,
  input  logic                                wr_en,
  input  logic [dbuf_aw-1:0]                  wr_addr,
  input  logic [cacc_dlv_pkg::dlv_data_w-1:0] wr_data,
  input  logic                                rd_en,
  input  logic [dbuf_aw-1:0]                  rd_addr,
  output logic [cacc_dlv_pkg::dlv_data_w-1:0] rd_data
);

  // one entry per finished output beat
  logic [cacc_dlv_pkg::dlv_data_w-1:0] mem [dbuf_depth];

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // registered read, data shows up the cycle after the request
  // the output stage only takes it when the request was actually popped
  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== src/cacc_dlv_out.sv ====
`timescale 1ns/1ps

module cacc_dlv_out (
  input  logic                                nvdla_core_clk,
  input  logic                                rst_n,
  input  logic                                rd_en,
  input  logic                                rd_layer_end,
  input  logic [cacc_dlv_pkg::dlv_data_w-1:0] rd_data,
  input  logic                                sdp_ready,
  output logic                                rd_ready,
  output logic                                sdp_valid,
  output logic [cacc_dlv_pkg::dlv_data_w-1:0] sdp_data,
  output logic                                sdp_layer_end
);

  logic                                rd_pend;
  logic                                pend_end;
  logic                                pull;
  logic [1:0]                          held;
  logic                                wr_sel;
  logic                                rd_sel;
  logic [cacc_dlv_pkg::dlv_data_w-1:0] beat_data [2];
  logic [1:0]                          beat_end;

  //////////////////////////////
  // read tracking
  //////////////////////////////

  // a popped read lands one cycle later, so it already owns a slot
  assign rd_ready = (held + 2'(rd_pend)) < 2'd2;
  assign pull     = sdp_valid & sdp_ready;

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend  <= 1'b0;
      pend_end <= 1'b0;
    end else begin
      rd_pend  <= rd_en & rd_ready;
      pend_end <= rd_layer_end;
    end
  end

  //////////////////////////////
  // two-entry holding FIFO
  //////////////////////////////

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      held   <= '0;
      wr_sel <= 1'b0;
      rd_sel <= 1'b0;
    end else begin
      if (rd_pend != pull) begin
        held <= rd_pend ? held + 1'b1 : held - 1'b1;
      end
      if (rd_pend) begin
        wr_sel <= ~wr_sel;
      end
      if (pull) begin
        rd_sel <= ~rd_sel;
      end
    end
  end

  // the layer-end flag rides next to its data
  always_ff @(posedge nvdla_core_clk) begin
    if (rd_pend) begin
      beat_data[wr_sel] <= rd_data;
      beat_end[wr_sel]  <= pend_end;
    end
  end

  assign sdp_valid     = (held != '0);
  assign sdp_data      = beat_data[rd_sel];
  assign sdp_layer_end = sdp_valid & beat_end[rd_sel];

  // a stalled beat must not move or change until the post-processor takes it
  a_sdp_hold: assert property (
    @(posedge nvdla_core_clk) disable iff (!rst_n)
    sdp_valid && !sdp_ready |=> sdp_valid && $stable(sdp_data)
  );

endmodule

// ==== src/cacc_dlv_pkg.sv ====
package cacc_dlv_pkg;

  // width of one output beat from the accumulator
  parameter int dlv_data_w = 32;

  // the APB side is a plain 8-bit address, 32-bit data slave
  parameter int apb_addr_w = 8;
  parameter int apb_data_w = 32;

  // accepted-beat counter, wide enough for one layer of traffic
  parameter int beat_cnt_w = 16;

  //////////////////////////////
  // register map
  //////////////////////////////

  // offsets as seen on paddr, all word aligned
  typedef enum logic [apb_addr_w-1:0] {
    reg_op_enable  = 8'h00,
    reg_status     = 8'h04,
    reg_beat_count = 8'h08
  } reg_offset_e;

  //////////////////////////////
  // controller FSM
  //////////////////////////////

  // st_idle drops every incoming beat, st_run takes all of them
  typedef enum logic {
    st_idle,
    st_run
  } ctrl_state_e;

endpackage

// ==== src/cacc_dlv_regs.sv ====
`timescale 1ns/1ps

module cacc_dlv_regs (
  input  logic                                nvdla_core_clk,
  input  logic                                rst_n,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [cacc_dlv_pkg::apb_addr_w-1:0] paddr,
  input  logic [cacc_dlv_pkg::apb_data_w-1:0] pwdata,
  input  logic                                done,
  input  logic                                dlv_accept,
  output logic [cacc_dlv_pkg::apb_data_w-1:0] prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic                                op_en
);

  cacc_dlv_pkg::reg_offset_e        reg_off;
  logic                             addr_hit;
  logic                             apb_wr;
  logic                             done_flag;
  logic [cacc_dlv_pkg::beat_cnt_w-1:0] beat_cnt;

  //////////////////////////////
  // address decode
  //////////////////////////////

  // the whole address is the offset, there is no base to strip
  assign reg_off = cacc_dlv_pkg::reg_offset_e'(paddr);

  always_comb begin
    case (reg_off)
      cacc_dlv_pkg::reg_op_enable,
      cacc_dlv_pkg::reg_status,
      cacc_dlv_pkg::reg_beat_count: addr_hit = 1'b1;
      default:                      addr_hit = 1'b0;
    endcase
  end

  // a write only takes effect in the access phase and only on a mapped offset
  assign apb_wr = psel & penable & pwrite & addr_hit;

  // no wait states, every access completes in its first access phase
  assign pready  = 1'b1;
  assign pslverr = psel & penable & ~addr_hit;

  // read mux, unused upper bits read back as zero
  always_comb begin
    prdata = '0;
    case (reg_off)
      cacc_dlv_pkg::reg_op_enable:  prdata[0] = op_en;
      cacc_dlv_pkg::reg_status:     prdata[0] = done_flag;
      cacc_dlv_pkg::reg_beat_count: prdata[cacc_dlv_pkg::beat_cnt_w-1:0] = beat_cnt;
      default:                      prdata = '0;
    endcase
  end

  //////////////////////////////
  // register state
  //////////////////////////////

  // op enable drops by itself once the layer is done, so software only arms it
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      op_en <= 1'b0;
    end else if (done) begin
      op_en <= 1'b0;
    end else if (apb_wr && reg_off == cacc_dlv_pkg::reg_op_enable) begin
      op_en <= pwdata[0];
    end
  end

  // sticky done, a set from hardware wins over a software clear in the same cycle
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      done_flag <= 1'b0;
    end else if (done) begin
      done_flag <= 1'b1;
    end else if (apb_wr && reg_off == cacc_dlv_pkg::reg_status && pwdata[0]) begin
      done_flag <= 1'b0;
    end
  end

  // arming a new operation restarts the count of accepted beats
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (apb_wr && reg_off == cacc_dlv_pkg::reg_op_enable && pwdata[0]) begin
      beat_cnt <= '0;
    end else if (dlv_accept) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // the setup phase must come first, penable may only rise with psel held
  a_penable_needs_psel: assert property (
    @(posedge nvdla_core_clk) disable iff (!rst_n)
    $rose(penable) |-> psel
  );

endmodule

// ==== src/cacc_dlv_top.sv ====
`timescale 1ns/1ps

module cacc_dlv_top #(
  parameter int dbuf_depth        = 16,
  parameter int dbuf_aw           = 4,
  parameter int ram_write_latency = 1
) (
  input  logic                                nvdla_core_clk,
  input  logic                                rst_n,
  // APB slave
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [cacc_dlv_pkg::apb_addr_w-1:0] paddr,
  input  logic [cacc_dlv_pkg::apb_data_w-1:0] pwdata,
  output logic [cacc_dlv_pkg::apb_data_w-1:0] prdata,
  output logic                                pready,
  output logic                                pslverr,
  // beats from the accumulator, no back-pressure
  input  logic                                dlv_valid,
  input  logic [cacc_dlv_pkg::dlv_data_w-1:0] dlv_data,
  input  logic                                dlv_stripe_end,
  input  logic                                dlv_layer_end,
  output logic [dbuf_aw:0]                    dbuf_free,
  // post-processor port
  output logic                                sdp_valid,
  output logic [cacc_dlv_pkg::dlv_data_w-1:0] sdp_data,
  output logic                                sdp_layer_end,
  input  logic                                sdp_ready
);

  logic                                op_en;
  logic                                done;
  logic                                dlv_accept;
  logic                                wr_en;
  logic [dbuf_aw-1:0]                  wr_addr;
  logic [cacc_dlv_pkg::dlv_data_w-1:0] wr_data;
  logic                                rd_en;
  logic [dbuf_aw-1:0]                  rd_addr;
  logic                                rd_layer_end;
  logic                                rd_ready;
  logic [cacc_dlv_pkg::dlv_data_w-1:0] rd_data;

  cacc_dlv_regs u_regs (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .done           (done),
    .dlv_accept     (dlv_accept),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .op_en          (op_en)
  );

  cacc_delivery_ctrl #(
    .dbuf_depth        (dbuf_depth),
    .dbuf_aw           (dbuf_aw),
    .ram_write_latency (ram_write_latency)
  ) u_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .op_en          (op_en),
    .dlv_valid      (dlv_valid),
    .dlv_data       (dlv_data),
    .dlv_stripe_end (dlv_stripe_end),
    .dlv_layer_end  (dlv_layer_end),
    .rd_ready       (rd_ready),
    .dlv_accept     (dlv_accept),
    .done           (done),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_layer_end   (rd_layer_end),
    .dbuf_free      (dbuf_free)
  );

  cacc_dlv_buffer #(
    .dbuf_depth (dbuf_depth),
    .dbuf_aw    (dbuf_aw)
  ) u_buffer (
    .nvdla_core_clk (nvdla_core_clk),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data)
  );

  cacc_dlv_out u_out (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .rd_en          (rd_en),
    .rd_layer_end   (rd_layer_end),
    .rd_data        (rd_data),
    .sdp_ready      (sdp_ready),
    .rd_ready       (rd_ready),
    .sdp_valid      (sdp_valid),
    .sdp_data       (sdp_data),
    .sdp_layer_end  (sdp_layer_end)
  );

endmodule

// ==== verification/tb_cacc_dlv.sv ====
`timescale 1ns/1ps

module tb_cacc_dlv;

  localparam int dbuf_depth = 16;
  localparam int dbuf_aw    = 4;

  logic                                clk;
  logic                                rst_n;
  logic                                psel;
  logic                                penable;
  logic                                pwrite;
  logic [cacc_dlv_pkg::apb_addr_w-1:0] paddr;
  logic [cacc_dlv_pkg::apb_data_w-1:0] pwdata;
  logic [cacc_dlv_pkg::apb_data_w-1:0] prdata;
  logic                                pready;
  logic                                pslverr;
  logic                                dlv_valid;
  logic [cacc_dlv_pkg::dlv_data_w-1:0] dlv_data;
  logic                                dlv_stripe_end;
  logic                                dlv_layer_end;
  logic [dbuf_aw:0]                    dbuf_free;
  logic                                sdp_valid;
  logic [cacc_dlv_pkg::dlv_data_w-1:0] sdp_data;
  logic                                sdp_layer_end;
  logic                                sdp_ready;

  // expected beats in delivery order, with their layer-end flags
  logic [cacc_dlv_pkg::dlv_data_w-1:0] exp_data[$];
  logic                                exp_end[$];
  bit                                  model_run;
  int                                  exp_beat_cnt;
  bit                                  stall_pat[1024];
  int                                  ready_mode;
  int                                  cyc;
  int                                  errors;
  int                                  test_err_start;
  int                                  tests_run;
  int                                  tests_failed;
  string                               cur_test;

  cacc_dlv_top #(
    .dbuf_depth        (dbuf_depth),
    .dbuf_aw           (dbuf_aw),
    .ram_write_latency (1)
  ) i_dut (
    .nvdla_core_clk (clk),
    .rst_n          (rst_n),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .dlv_valid      (dlv_valid),
    .dlv_data       (dlv_data),
    .dlv_stripe_end (dlv_stripe_end),
    .dlv_layer_end  (dlv_layer_end),
    .dbuf_free      (dbuf_free),
    .sdp_valid      (sdp_valid),
    .sdp_data       (sdp_data),
    .sdp_layer_end  (sdp_layer_end),
    .sdp_ready      (sdp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // reference model and checks
  //////////////////////////////

  // a beat is taken only while an operation runs, and the layer-ending beat stops it
  function automatic void ref_accept(input logic [cacc_dlv_pkg::dlv_data_w-1:0] data,
                                     input logic last);
    if (model_run) begin
      exp_data.push_back(data);
      exp_end.push_back(last);
      exp_beat_cnt++;
      if (last) begin
        model_run = 1'b0;
      end
    end
  endfunction

  task automatic check_beat(input logic [cacc_dlv_pkg::dlv_data_w-1:0] exp_d, input logic exp_e,
                            input logic [cacc_dlv_pkg::dlv_data_w-1:0] act_d, input logic act_e);
    if (exp_d !== act_d || exp_e !== act_e) begin
      errors++;
      $display("Error %s: beat expected %h/%b actual %h/%b", cur_test, exp_d, exp_e, act_d, act_e);
    end
  endtask

  task automatic check_reg(input string what, input logic [cacc_dlv_pkg::apb_data_w-1:0] exp_v,
                           input logic [cacc_dlv_pkg::apb_data_w-1:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("Error %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
    end
  endtask

  task automatic check_free(input logic [dbuf_aw:0] exp_v);
    if (exp_v !== dbuf_free) begin
      errors++;
      $display("Error %s: dbuf_free expected %0d actual %0d", cur_test, exp_v, dbuf_free);
    end
  endtask

  task automatic check_bit(input string what, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("Error %s: %s expected %b actual %b", cur_test, what, exp_v, act_v);
    end
  endtask

  // the monitor samples at the falling edge, the transfer happens at the next rising edge
  always @(negedge clk) begin
    if (rst_n && sdp_valid && sdp_ready) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("test %s got an sdp beat %h while none was expected", cur_test, sdp_data);
      end else begin
        check_beat(exp_data.pop_front(), exp_end.pop_front(), sdp_data, sdp_layer_end);
      end
    end
  end

  // post-processor ready, 0 is always ready, 1 is random stalls, 2 is held low
  always @(posedge clk) begin
    #1;
    cyc++;
    case (ready_mode)
      0:       sdp_ready = 1'b1;
      1:       sdp_ready = stall_pat[cyc % 1024];
      default: sdp_ready = 1'b0;
    endcase
  end

  //////////////////////////////
  // bus and stimulus tasks
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s in test %s", why, cur_test);
    $display("TB FAILED");
    $finish;
  endtask

  // one APB transfer, called and returning 1 ns after a rising edge
  task automatic apb_transfer(input bit wr, input logic [cacc_dlv_pkg::apb_addr_w-1:0] addr,
                              input logic [cacc_dlv_pkg::apb_data_w-1:0] wdata,
                              output logic [cacc_dlv_pkg::apb_data_w-1:0] rdata,
                              output logic err);
    int waited;
    waited  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited > 16) begin
        abort_run("APB slave never raised pready");
      end
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [cacc_dlv_pkg::apb_addr_w-1:0] addr,
                          output logic [cacc_dlv_pkg::apb_data_w-1:0] rdata, output logic err);
    apb_transfer(1'b0, addr, '0, rdata, err);
  endtask

  task automatic write_reg(input logic [cacc_dlv_pkg::apb_addr_w-1:0] addr,
                           input logic [cacc_dlv_pkg::apb_data_w-1:0] wdata);
    logic [cacc_dlv_pkg::apb_data_w-1:0] unused_rd;
    logic                                unused_err;
    apb_transfer(1'b1, addr, wdata, unused_rd, unused_err);
  endtask

  // the controller enters st_run one cycle after op enable is written
  task automatic arm_op();
    write_reg(cacc_dlv_pkg::reg_op_enable, 32'h1);
    @(posedge clk);
    #1;
    model_run    = 1'b1;
    exp_beat_cnt = 0;
  endtask

  // the accumulator side holds a beat back only while the buffer has no free entry
  task automatic send_beat(input logic [cacc_dlv_pkg::dlv_data_w-1:0] data, input logic last);
    int waited;
    waited = 0;
    while (dbuf_free == '0) begin
      dlv_valid = 1'b0;
      @(posedge clk);
      #1;
      waited++;
      if (waited > 500) begin
        abort_run("dbuf_free stayed at zero");
      end
    end
    dlv_valid      = 1'b1;
    dlv_data       = data;
    dlv_stripe_end = last;
    dlv_layer_end  = last;
    ref_accept(data, last);
    @(posedge clk);
    #1;
    dlv_valid      = 1'b0;
    dlv_stripe_end = 1'b0;
    dlv_layer_end  = 1'b0;
  endtask

  task automatic send_layer(input int n);
    for (int i = 0; i < n; i++) begin
      send_beat($urandom(), i == n - 1);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 2000) begin
        abort_run("expected sdp beats never arrived");
      end
    end
  endtask

  task automatic wait_free(input logic [dbuf_aw:0] level);
    int waited;
    waited = 0;
    while (dbuf_free != level) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 200) begin
        abort_run($sformatf("dbuf_free never reached %0d", level));
      end
    end
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [cacc_dlv_pkg::apb_data_w-1:0] rd;
    logic                                err;
    void'($urandom(32'hbabb_1fa2));
    for (int i = 0; i < 1024; i++) begin
      stall_pat[i] = ($urandom() % 4) != 0;
    end
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    dlv_valid = 1'b0;
    dlv_data = '0;
    dlv_stripe_end = 1'b0;
    dlv_layer_end = 1'b0;
    sdp_ready = 1'b1;
    ready_mode = 0;
    cur_test = "reset";
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset_values");
    read_reg(cacc_dlv_pkg::reg_op_enable, rd, err);
    check_reg("op enable", '0, rd);
    read_reg(cacc_dlv_pkg::reg_status, rd, err);
    check_reg("status", '0, rd);
    read_reg(cacc_dlv_pkg::reg_beat_count, rd, err);
    check_reg("beat count", '0, rd);
    check_bit("pslverr on mapped offset", 1'b0, err);
    read_reg(8'h0c, rd, err);
    check_bit("pslverr on unmapped offset", 1'b1, err);
    check_free(dbuf_depth);
    check_bit("sdp_valid", 1'b0, sdp_valid);
    finish_test();

    // 40 random beats under random post-processor stalls
    start_test("data_order");
    ready_mode = 1;
    arm_op();
    send_layer(40);
    wait_drain();
    finish_test();

    // two layers with a re-arm between them, the post-processor stalls meanwhile
    // so both last-beat tags sit in the queue at once
    start_test("layer_end");
    ready_mode = 2;
    arm_op();
    send_layer(5);
    arm_op();
    send_layer(3);
    ready_mode = 1;
    wait_drain();
    finish_test();

    start_test("done_and_count");
    read_reg(cacc_dlv_pkg::reg_status, rd, err);
    check_reg("status", 32'h1, rd);
    read_reg(cacc_dlv_pkg::reg_op_enable, rd, err);
    check_reg("op enable", '0, rd);
    read_reg(cacc_dlv_pkg::reg_beat_count, rd, err);
    check_reg("beat count", exp_beat_cnt, rd);
    write_reg(cacc_dlv_pkg::reg_status, 32'h1);
    read_reg(cacc_dlv_pkg::reg_status, rd, err);
    check_reg("status after clear", '0, rd);
    finish_test();

    // with the output stage full, only its two beats have left the buffer
    start_test("back_pressure");
    ready_mode = 2;
    arm_op();
    send_layer(dbuf_depth);
    wait_free(2);
    repeat (5) @(posedge clk);
    #1;
    check_free(2);
    check_bit("sdp_valid while stalled", 1'b1, sdp_valid);
    ready_mode = 0;
    wait_drain();
    // every beat left the buffer before it reached the post-processor
    check_free(dbuf_depth);
    finish_test();

    // op enable is 0 here since the last layer ended
    start_test("ignored_beats");
    send_layer(5);
    repeat (20) @(posedge clk);
    #1;
    read_reg(cacc_dlv_pkg::reg_beat_count, rd, err);
    check_reg("beat count", exp_beat_cnt, rd);
    check_free(dbuf_depth);
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
